// File: design/audio_pkg.sv
// Shared widths, configuration bit positions and enums for the sound output path.
// Imported by every RTL block and by the testbench.
`default_nettype none

package audio_pkg;

    // PCM sample width, also the command data field
    localparam int SAMPLE_W = 16;

    // Padded code fed to the modulators
    localparam int PCM_W = 20;

    // Clocks between modulator steps, same as ring length
    localparam int CEN_PERIOD = 4;

    // Flag positions inside the data field of a config command
    localparam int CFG_SIGNED_BIT = 0;
    localparam int CFG_MONO_BIT   = 1;
    localparam int CFG_MUTE_BIT   = 2;

    // Converted sample used while muted, quarter density
    localparam logic [SAMPLE_W-1:0] MUTE_CODE = 16'h8000;

    // Host command opcodes
    typedef enum logic [1:0] {
        OP_WRITE_L  = 2'd0,
        OP_WRITE_R  = 2'd1,
        OP_WRITE_LR = 2'd2,
        OP_CONFIG   = 2'd3
    } dac_op_e;

    // Four-phase slave states
    typedef enum logic {
        HS_IDLE = 1'b0,
        HS_ACK  = 1'b1
    } hs_state_e;

endpackage

`default_nettype wire

// File: design/pcm_command_decoder.sv
// Host command port of the sound path. Runs the four-phase req/ack slave,
// stores the raw left/right samples and the format flags, and produces the
// registered 20-bit padded codes for the two modulators.
`timescale 1ns/1ps
`default_nettype none

module pcm_command_decoder
    import audio_pkg::*;
(
    input  logic                clk_dac,
    input  logic                rst,
    input  logic                req_i,
    input  dac_op_e             op_i,
    input  logic [SAMPLE_W-1:0] data_i,
    output logic                ack_o,
    output logic [PCM_W-1:0]    pcm_left_o,
    output logic [PCM_W-1:0]    pcm_right_o,
    output logic                mono_o
);

    // Zero bits appended below the sample in the padded code
    localparam int PAD_LSB = PCM_W - SAMPLE_W - 1;

    hs_state_e           state;

    logic [SAMPLE_W-1:0] raw_left;
    logic [SAMPLE_W-1:0] raw_right;
    logic                signed_fmt;
    logic                mono_cfg;
    logic                mute;

    // Sign flip for signed input, mute override, then padding
    function automatic logic [PCM_W-1:0] pad_sample(
        input logic [SAMPLE_W-1:0] sample,
        input logic                is_signed,
        input logic                is_muted
    );
        logic [SAMPLE_W-1:0] conv;
        begin
            conv = {sample[SAMPLE_W-1] ^ is_signed, sample[SAMPLE_W-2:0]};
            if (is_muted) begin
                conv = MUTE_CODE;
            end
            pad_sample = {1'b0, conv, {PAD_LSB{1'b0}}};
        end
    endfunction

    // Handshake and command capture
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            state      <= HS_IDLE;
            raw_left   <= '0;
            raw_right  <= '0;
            signed_fmt <= 1'b0;
            mono_cfg   <= 1'b0;
            mute       <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (req_i) begin
                        state <= HS_ACK;
                        case (op_i)
                            OP_WRITE_L: begin
                                raw_left <= data_i;
                            end
                            OP_WRITE_R: begin
                                raw_right <= data_i;
                            end
                            OP_WRITE_LR: begin
                                raw_left  <= data_i;
                                raw_right <= data_i;
                            end
                            OP_CONFIG: begin
                                signed_fmt <= data_i[CFG_SIGNED_BIT];
                                mono_cfg   <= data_i[CFG_MONO_BIT];
                                mute       <= data_i[CFG_MUTE_BIT];
                            end
                            default: begin
                                state <= HS_ACK;
                            end
                        endcase
                    end
                end
                HS_ACK: begin
                    // Hold ack until the host drops req
                    if (!req_i) begin
                        state <= HS_IDLE;
                    end
                end
                default: begin
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    assign ack_o = (state == HS_ACK);

    // Mono flag follows the stored config one cycle later
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            mono_o <= 1'b0;
        end else begin
            mono_o <= mono_cfg;
        end
    end

    // Codes are rebuilt every clock, so flag changes reach stored samples too
    always_ff @(posedge clk_dac) begin
        pcm_left_o  <= pad_sample(raw_left, signed_fmt, mute);
        pcm_right_o <= pad_sample(raw_right, signed_fmt, mute);
    end

    // The host keeps req high until it sees ack
    ack_follows_req: assert property (
        @(posedge clk_dac) disable iff (rst)
        $rose(ack_o) |-> req_i
    ) else $error("ack_o rose while req_i was low");

endmodule

`default_nettype wire

// File: design/sigma_delta_modulator.sv
// First-order error-feedback 1-bit DAC. The carry out of the accumulator is
// the output bit, so the density of ones is pcm_i / 2**PCM_W.
// One instance per audio channel, stepped on the shared clock enable.
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_modulator
    import audio_pkg::*;
(
    input  logic             clk_dac,
    input  logic             rst,
    input  logic             cen_i,
    input  logic [PCM_W-1:0] pcm_i,
    output logic             bit_o
);

    // Extra top bit holds the carry of the last step
    logic [PCM_W:0] acc;
    logic [PCM_W:0] acc_sum;

    // Carry is dropped before the next addition, the residue is the error
    assign acc_sum = {1'b0, acc[PCM_W-1:0]} + {1'b0, pcm_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (cen_i) begin
            acc <= acc_sum;
        end
    end

    assign bit_o = acc[PCM_W];

    // Leading zero of the padded code keeps density at or below one half
    pcm_top_clear: assert property (
        @(posedge clk_dac) disable iff (rst)
        cen_i |-> !pcm_i[PCM_W-1]
    ) else $error("pcm_i top bit set on a modulator step");

endmodule

`default_nettype wire

// File: design/dac_output_stage.sv
// Output side of the sound path. Owns the rotating clock-enable ring for the
// modulators and registers the two pulse streams onto the board pins.
// In mono mode the left stream drives both pins.
`timescale 1ns/1ps
`default_nettype none

module dac_output_stage
    import audio_pkg::*;
(
    input  logic clk_dac,
    input  logic rst,
    input  logic mono_i,
    input  logic bit_left_i,
    input  logic bit_right_i,
    output logic cen_o,
    output logic snd_pwm_left_o,
    output logic snd_pwm_right_o
);

    // Single one circulating, high once every CEN_PERIOD clocks
    logic [CEN_PERIOD-1:0] cen_ring;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_ring <= {{(CEN_PERIOD-1){1'b0}}, 1'b1};
        end else begin
            cen_ring <= {cen_ring[CEN_PERIOD-2:0], cen_ring[CEN_PERIOD-1]};
        end
    end

    assign cen_o = cen_ring[0];

    // Pin registers
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            snd_pwm_left_o  <= 1'b0;
            snd_pwm_right_o <= 1'b0;
        end else begin
            snd_pwm_left_o <= bit_left_i;
            // Mirror left onto right when mono
            if (mono_i) begin
                snd_pwm_right_o <= bit_left_i;
            end else begin
                snd_pwm_right_o <= bit_right_i;
            end
        end
    end

    // Losing or duplicating the token would change the step rate
    ring_one_hot: assert property (
        @(posedge clk_dac) disable iff (rst)
        $onehot(cen_ring)
    ) else $error("clock-enable ring is not one-hot");

endmodule

`default_nettype wire

// File: design/audio_dac_top.sv
// Sound output subsystem on clk_dac. A host loads PCM samples and the format
// flags over a four-phase req/ack port; two sigma-delta modulators drive the
// 1-bit left and right pins through a registered output stage.
`timescale 1ns/1ps
`default_nettype none

module audio_dac_top
    import audio_pkg::*;
(
    input  logic                clk_dac,
    input  logic                rst,
    // Host command port
    input  logic                req_i,
    input  dac_op_e             op_i,
    input  logic [SAMPLE_W-1:0] data_i,
    output logic                ack_o,
    // Pulse-density outputs
    output logic                snd_pwm_left_o,
    output logic                snd_pwm_right_o
);

    logic [PCM_W-1:0] pcm_left;
    logic [PCM_W-1:0] pcm_right;
    logic             mono;
    logic             cen;
    logic             bit_left;
    logic             bit_right;

    pcm_command_decoder decode_inst (
        .clk_dac     (clk_dac),
        .rst         (rst),
        .req_i       (req_i),
        .op_i        (op_i),
        .data_i      (data_i),
        .ack_o       (ack_o),
        .pcm_left_o  (pcm_left),
        .pcm_right_o (pcm_right),
        .mono_o      (mono)
    );

    // Both channels step on the same enable
    sigma_delta_modulator execute_left_inst (
        .clk_dac (clk_dac),
        .rst     (rst),
        .cen_i   (cen),
        .pcm_i   (pcm_left),
        .bit_o   (bit_left)
    );

    sigma_delta_modulator execute_right_inst (
        .clk_dac (clk_dac),
        .rst     (rst),
        .cen_i   (cen),
        .pcm_i   (pcm_right),
        .bit_o   (bit_right)
    );

    dac_output_stage result_inst (
        .clk_dac         (clk_dac),
        .rst             (rst),
        .mono_i          (mono),
        .bit_left_i      (bit_left),
        .bit_right_i     (bit_right),
        .cen_o           (cen),
        .snd_pwm_left_o  (snd_pwm_left_o),
        .snd_pwm_right_o (snd_pwm_right_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Free-running clk_dac for the testbench, 10 ns period.
// Starts low at time zero.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    localparam real HALF_PERIOD = 5.0;

    initial begin
        clk_o = 1'b0;
    end

    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: tests/audio_dac_tb.sv
// Directed testbench for audio_dac_top. Commands go over the four-phase port,
// then the ones on each output pin are counted over a fixed window and
// compared with the density expected from the padded-code rules.
`timescale 1ns/1ps
`default_nettype none

module audio_dac_tb
    import audio_pkg::*;
();

    localparam int SETTLE_CYCLES  = 64;
    localparam int MEASURE_CYCLES = 4096;
    localparam int TOLERANCE      = 8;
    localparam int ACK_WAIT       = 16;
    // 13 windows of 4160 cycles plus reset and roughly 30 handshakes
    localparam int CYCLE_LIMIT    = 60000;

    logic                clk_dac;
    logic                rst;
    logic                req;
    dac_op_e             op;
    logic [SAMPLE_W-1:0] data;
    logic                ack;
    logic                snd_pwm_left;
    logic                snd_pwm_right;

    // Model of what the DUT should hold
    logic [SAMPLE_W-1:0] cur_left;
    logic [SAMPLE_W-1:0] cur_right;
    logic                cur_signed;
    logic                cur_mono;
    logic                cur_mute;

    int value_errors;
    int handshake_errors;
    int cycle_count;
    int seed;

    tb_clock_gen clock_inst (
        .clk_o (clk_dac)
    );

    audio_dac_top audio_dac_top_inst (
        .clk_dac         (clk_dac),
        .rst             (rst),
        .req_i           (req),
        .op_i            (op),
        .data_i          (data),
        .ack_o           (ack),
        .snd_pwm_left_o  (snd_pwm_left),
        .snd_pwm_right_o (snd_pwm_right)
    );

    // Converted 16-bit value: sign bit flipped when signed, forced when muted
    function automatic logic [SAMPLE_W-1:0] converted(input logic [SAMPLE_W-1:0] sample);
        logic [SAMPLE_W-1:0] conv;
        begin
            conv = sample;
            if (cur_signed) begin
                conv[SAMPLE_W-1] = ~sample[SAMPLE_W-1];
            end
            if (cur_mute) begin
                conv = MUTE_CODE;
            end
            converted = conv;
        end
    endfunction

    // Padded code is conv * 8 out of 2**20
    function automatic int expected_ones(input logic [SAMPLE_W-1:0] conv);
        longint scaled;
        begin
            scaled = longint'(conv) * MEASURE_CYCLES * 8;
            expected_ones = int'(scaled >> 20);
        end
    endfunction

    function automatic bit within_tolerance(input int got, input int expected);
        int diff;
        begin
            diff = got - expected;
            if (diff < 0) begin
                diff = -diff;
            end
            within_tolerance = (diff <= TOLERANCE);
        end
    endfunction

    // Full four-phase handshake, the model is updated as the command is sent
    task automatic send_cmd(input dac_op_e cmd_op, input logic [SAMPLE_W-1:0] cmd_data);
        int waited;
        begin
            @(posedge clk_dac);
            req  <= 1'b1;
            op   <= cmd_op;
            data <= cmd_data;
            waited = 0;
            @(negedge clk_dac);
            while (!ack && waited < ACK_WAIT) begin
                @(negedge clk_dac);
                waited++;
            end
            assert (ack) else begin
                handshake_errors++;
                $display("Handshake failure: ack_o did not rise within %0d cycles", ACK_WAIT);
            end
            case (cmd_op)
                OP_WRITE_L: cur_left = cmd_data;
                OP_WRITE_R: cur_right = cmd_data;
                OP_WRITE_LR: begin
                    cur_left  = cmd_data;
                    cur_right = cmd_data;
                end
                default: begin
                    cur_signed = cmd_data[CFG_SIGNED_BIT];
                    cur_mono   = cmd_data[CFG_MONO_BIT];
                    cur_mute   = cmd_data[CFG_MUTE_BIT];
                end
            endcase
            @(posedge clk_dac);
            req <= 1'b0;
            waited = 0;
            @(negedge clk_dac);
            while (ack && waited < ACK_WAIT) begin
                @(negedge clk_dac);
                waited++;
            end
            assert (!ack) else begin
                handshake_errors++;
                $display("Handshake failure: ack_o stayed high after req_i was lowered");
            end
        end
    endtask

    task automatic set_config(input logic is_signed, input logic is_mono, input logic is_mute);
        logic [SAMPLE_W-1:0] cfg;
        begin
            cfg = '0;
            cfg[CFG_SIGNED_BIT] = is_signed;
            cfg[CFG_MONO_BIT]   = is_mono;
            cfg[CFG_MUTE_BIT]   = is_mute;
            send_cmd(OP_CONFIG, cfg);
        end
    endtask

    // Settle, count ones on both pins, compare with the model
    task automatic check_density(input string tag);
        int ones_left;
        int ones_right;
        int mismatches;
        int exp_left;
        int exp_right;
        begin
            ones_left  = 0;
            ones_right = 0;
            mismatches = 0;
            repeat (SETTLE_CYCLES) @(negedge clk_dac);
            repeat (MEASURE_CYCLES) begin
                @(negedge clk_dac);
                if (snd_pwm_left) begin
                    ones_left++;
                end
                if (snd_pwm_right) begin
                    ones_right++;
                end
                if (snd_pwm_left != snd_pwm_right) begin
                    mismatches++;
                end
            end
            exp_left = expected_ones(converted(cur_left));
            // Mono drives the right pin from the left stream
            exp_right = expected_ones(converted(cur_mono ? cur_left : cur_right));
            assert (within_tolerance(ones_left, exp_left)) else begin
                value_errors++;
                $display("error at %0t ns: %s left counted %0d ones, expected %0d",
                         $time, tag, ones_left, exp_left);
            end
            assert (within_tolerance(ones_right, exp_right)) else begin
                value_errors++;
                $display("error at %0t ns: %s right counted %0d ones, expected %0d",
                         $time, tag, ones_right, exp_right);
            end
            if (cur_mono) begin
                assert (mismatches == 0) else begin
                    value_errors++;
                    $display("error at %0t ns: %s mono pins differ on %0d cycles",
                             $time, tag, mismatches);
                end
            end
        end
    endtask

    task automatic test_reset_and_both();
        begin
            check_density("after reset");
            send_cmd(OP_WRITE_LR, 16'h4000);
            check_density("unsigned both 4000");
        end
    endtask

    task automatic test_stereo_split();
        begin
            set_config(1'b0, 1'b0, 1'b0);
            send_cmd(OP_WRITE_L, 16'h2000);
            send_cmd(OP_WRITE_R, 16'h6000);
            check_density("stereo split");
        end
    endtask

    task automatic test_signed_format();
        begin
            set_config(1'b1, 1'b0, 1'b0);
            send_cmd(OP_WRITE_LR, 16'h0000);
            check_density("signed zero");
            set_config(1'b0, 1'b0, 1'b0);
            send_cmd(OP_WRITE_L, 16'h3000);
            send_cmd(OP_WRITE_R, 16'hA000);
            check_density("unsigned stored");
            // Same stored samples read as signed
            set_config(1'b1, 1'b0, 1'b0);
            check_density("signed reinterpret");
        end
    endtask

    task automatic test_mono_mirror();
        begin
            set_config(1'b0, 1'b1, 1'b0);
            send_cmd(OP_WRITE_L, 16'h5000);
            send_cmd(OP_WRITE_R, 16'h1000);
            check_density("mono mirror");
        end
    endtask

    task automatic test_mute();
        begin
            set_config(1'b0, 1'b0, 1'b1);
            check_density("muted");
            set_config(1'b0, 1'b0, 1'b0);
            check_density("unmuted");
        end
    endtask

    task automatic test_random_samples();
        int rnd;
        begin
            for (int i = 0; i < 4; i++) begin
                set_config(i[0], 1'b0, 1'b0);
                rnd = $random(seed);
                send_cmd(OP_WRITE_L, rnd[SAMPLE_W-1:0]);
                rnd = $random(seed);
                send_cmd(OP_WRITE_R, rnd[SAMPLE_W-1:0]);
                check_density(i[0] ? "random signed" : "random unsigned");
            end
        end
    endtask

    // Guard against a stuck run
    always @(posedge clk_dac) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst              = 1'b1;
        req              = 1'b0;
        op               = OP_WRITE_L;
        data             = '0;
        cur_left         = '0;
        cur_right        = '0;
        cur_signed       = 1'b0;
        cur_mono         = 1'b0;
        cur_mute         = 1'b0;
        value_errors     = 0;
        handshake_errors = 0;
        cycle_count      = 0;
        seed             = 32'h80c6;
        repeat (10) @(posedge clk_dac);
        rst <= 1'b0;

        test_reset_and_both();
        test_stereo_split();
        test_signed_format();
        test_mono_mirror();
        test_mute();
        test_random_samples();

        $display("Errors: %0d value, %0d handshake", value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/audio_pkg.sv
design/pcm_command_decoder.sv
design/sigma_delta_modulator.sv
design/dac_output_stage.sv
design/audio_dac_top.sv
tests/tb_clock_gen.sv
tests/audio_dac_tb.sv

// File: Makefile
# Verilator simulation of the sound output path.
# Example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= audio_dac_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
